/* dv/pong_model.svh */
// One step under gravity with the wall bounce
function automatic void step_ball(inout int x, inout int y, inout int vy, inout int g,
                                  input bit right, input bit up);
    int y_wall;
    int vy_new;
    y_wall = up ? int'(screen_h_hi) - 1 : int'(screen_h_lo) - 1;
    vy_new = (g == 3) ? vy + 1 : vy;  // Gravity on every fourth step
    y      = y + vy;
    vy     = vy_new;
    g      = (g + 1) % 4;
    if (y >= y_wall) begin
        y  = y_wall;
        vy = -vy_new;
    end else if (y <= 0) begin
        y  = 0;
        vy = -vy_new;
    end
    if (right) begin
        x = x + int'(x_step);
    end else begin
        x = (x > int'(x_step)) ? x - int'(x_step) : 0;
    end
endfunction

function automatic int paddle_column(input bit up);
    return up ? int'(paddle_x_hi) : int'(paddle_x_lo);
endfunction

function automatic bit paddle_near(input int y, input int py);
    return (y - py <= int'(paddle_half)) && (py - y <= int'(paddle_half));
endfunction

// Height of the ball when it first reaches the paddle column
function automatic int y_at_column(input int y0, input int vy0, input int g0, input bit up);
    int x;
    int y;
    int vy;
    int g;
    x  = int'(x_serve);
    y  = y0;
    vy = vy0;
    g  = g0;
    while (x < paddle_column(up)) begin
        step_ball(x, y, vy, g, 1'b1, up);
    end
    return y;
endfunction

function automatic int serve_period(input bit fast);
    return fast ? int'(step_base) : 2 * int'(step_base);
endfunction

function automatic int hit_period(input int motion);
    int s;
    s = (motion < int'(speed_min)) ? int'(speed_min) : motion;
    s = (s > int'(speed_max)) ? int'(speed_max) : s;
    return int'(step_base) / s;
endfunction

function automatic handoff_t ball_word(input int y, input int vy, input int g, input bit fast);
    handoff_t w;
    w              = '0;
    w.ball.kind    = msg_ball;
    w.ball.y       = y[9:0];
    w.ball.vy      = vy[7:0];
    w.ball.gravity = g[1:0];
    w.ball.fast    = fast;
    return w;
endfunction

function automatic handoff_t notice_word(input bit win);
    handoff_t w;
    w             = '0;
    w.notice.kind = msg_lose;
    w.notice.win  = win;
    return w;
endfunction

/* dv/tb_pong_board.sv */
`timescale 1ns/1ps

module tb_pong_board import pong_pkg::*; ();

    localparam int n_tests        = 6;
    localparam int steps_per_test = 140;
    localparam int cycle_limit    = (steps_per_test * 2 * int'(step_base) + 200) * n_tests;

    logic                 clk_25MHZ;
    logic                 reset;
    logic                 upscale;
    logic                 frame;
    logic [9:0]           paddle_y;
    logic                 rx_done;
    handoff_t             rx_word;
    logic                 tx_done;
    logic                 tx_request;
    logic [handoff_w-1:0] tx_word;
    logic [9:0]           ball_x;
    logic [9:0]           ball_y;
    logic                 game_over;
    logic [7:0]           score;
    game_state_t          state_led;

    int         seed   = 77;
    int         cycles = 0;
    int         m_x    = 0;  // Model ball owned by the compare process
    int         m_y    = 0;
    int         m_vy   = 0;
    int         m_g    = 0;
    bit         m_right;
    int         m_period;
    int         last_change;
    bit         first_step;
    logic [9:0] seen_x = '0;
    logic [9:0] seen_y = '0;
    bit         load_pending = 1'b0;  // Serve values for the compare process
    int         ld_y;
    int         ld_vy;
    int         ld_g;
    int         ld_period;
    int         hit_motion;
    logic [7:0] exp_score = '0;

    `include "pong_model.svh"

    pong_board_top i_dut (
        .clk_25MHZ  (clk_25MHZ),
        .reset      (reset),
        .upscale    (upscale),
        .frame      (frame),
        .paddle_y   (paddle_y),
        .rx_done    (rx_done),
        .rx_word    (rx_word),
        .tx_done    (tx_done),
        .tx_request (tx_request),
        .tx_word    (tx_word),
        .ball_x     (ball_x),
        .ball_y     (ball_y),
        .game_over  (game_over),
        .score      (score),
        .state_led  (state_led)
    );

    initial begin
        clk_25MHZ = 1'b0;
        forever #20 clk_25MHZ = ~clk_25MHZ;
    end

    task automatic stop_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_position(input string name, input logic [9:0] got,
                                  input logic [9:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_word(input handoff_t got, input handoff_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t tx_word got %h expected %h", $time, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_score(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t score got %0d expected %0d", $time, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_state(input game_state_t got, input game_state_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t state_led got %0d expected %0d", $time, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_period(input logic [period_w-1:0] got, input logic [period_w-1:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t step_interval got %0d expected %0d", $time, got, exp);
            stop_with_failure();
        end
    endtask

    // Every change of the ball is a serve or one step of the model
    always @(negedge clk_25MHZ) begin
        if (!reset && (ball_x !== seen_x || ball_y !== seen_y)) begin
            if (load_pending) begin
                m_x          = int'(x_serve);
                m_y          = ld_y;
                m_vy         = ld_vy;
                m_g          = ld_g;
                m_right      = 1'b1;
                m_period     = ld_period;
                first_step   = 1'b1;
                load_pending = 1'b0;
            end else begin
                step_ball(m_x, m_y, m_vy, m_g, m_right, upscale);
                if (!first_step) begin
                    check_period(cycles - last_change, m_period + 1);
                end
                first_step = 1'b0;
                if (m_right && m_x >= paddle_column(upscale) && paddle_near(m_y, paddle_y)) begin
                    m_right  = 1'b0;  // Paddle return
                    m_period = hit_period(hit_motion);
                end
            end
            check_position("ball_x", ball_x, m_x[9:0]);
            check_position("ball_y", ball_y, m_y[9:0]);
            seen_x      = ball_x;
            seen_y      = ball_y;
            last_change = cycles;
        end
    end

    always @(posedge clk_25MHZ) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycles);
            stop_with_failure();
        end
    end

    task automatic serve(input bit up, input bit fast);
        int h;
        int hold;
        h = up ? int'(screen_h_hi) : int'(screen_h_lo);
        @(posedge clk_25MHZ);
        ld_y         = 40 + int'($unsigned($random(seed)) % (h - 80));
        ld_vy        = int'($unsigned($random(seed)) % 13) - 6;
        ld_g         = int'($unsigned($random(seed)) % 4);
        ld_period    = serve_period(fast);
        load_pending = 1'b1;
        upscale <= up;
        rx_word <= ball_word(ld_y, ld_vy, ld_g, fast);
        rx_done <= 1'b1;
        hold = 2 + int'($unsigned($random(seed)) % 4);
        repeat (hold) @(posedge clk_25MHZ);
        check_state(state_led, wait_release);
        rx_done <= 1'b0;
        repeat (2) @(posedge clk_25MHZ);
        check_state(state_led, run_right);
    endtask

    // Second of two frames sets the measured speed
    task automatic move_paddle(input int start, input int target);
        @(posedge clk_25MHZ);
        paddle_y <= start[9:0];
        frame    <= 1'b1;
        @(posedge clk_25MHZ);
        frame    <= 1'b0;
        @(posedge clk_25MHZ);
        paddle_y <= target[9:0];
        frame    <= 1'b1;
        @(posedge clk_25MHZ);
        frame    <= 1'b0;
    endtask

    // Delayed tx_done with tx_word held steady
    task automatic finish_send(input handoff_t expect_word);
        int delay;
        while (!tx_request) @(posedge clk_25MHZ);
        delay = int'($unsigned($random(seed)) % 24);
        check_word(handoff_t'(tx_word), expect_word);
        repeat (delay) begin
            @(posedge clk_25MHZ);
            check_flag("tx_request", tx_request, 1'b1);
            check_word(handoff_t'(tx_word), expect_word);
        end
        tx_done <= 1'b1;
        while (tx_request) @(posedge clk_25MHZ);
        tx_done <= 1'b0;
    endtask

    task automatic rally(input bit up, input bit fast);
        int target;
        int start;
        serve(up, fast);
        target     = y_at_column(ld_y, ld_vy, ld_g, up);
        hit_motion = int'($unsigned($random(seed)) % 20);
        start      = (target >= hit_motion) ? target - hit_motion : target + hit_motion;
        move_paddle(start, target);
        while (!tx_request) @(posedge clk_25MHZ);
        exp_score = exp_score + 8'd1;
        check_score(score, exp_score);
        finish_send(ball_word(m_y, m_vy, m_g, 1'b1));  // Returned ball flies at hit speed
        check_state(state_led, wait_result);
    endtask

    task automatic win_notice();
        @(posedge clk_25MHZ);
        rx_word <= notice_word(1'b1);
        rx_done <= 1'b1;
        repeat (3) @(posedge clk_25MHZ);
        check_state(state_led, wait_release);
        rx_done <= 1'b0;
        repeat (8) @(posedge clk_25MHZ);
        check_state(state_led, idle);
        check_position("ball_x", ball_x, m_x[9:0]);
        check_position("ball_y", ball_y, m_y[9:0]);
    endtask

    task automatic miss(input bit up);
        int target;
        int away;
        int h;
        h = up ? int'(screen_h_hi) : int'(screen_h_lo);
        serve(up, $unsigned($random(seed)) % 2);
        target = y_at_column(ld_y, ld_vy, ld_g, up);
        away   = (target < h / 2) ? h - 1 : 0;  // Far side of the screen
        move_paddle(away, away);
        finish_send(notice_word(1'b1));
        check_flag("game_over", game_over, 1'b1);
        check_state(state_led, idle);
        check_score(score, exp_score);
    endtask

    initial begin
        int r;
        reset    = 1'b1;
        upscale  = 1'b1;
        frame    = 1'b0;
        paddle_y = '0;
        rx_done  = 1'b0;
        rx_word  = '0;
        tx_done  = 1'b0;
        repeat (5) @(posedge clk_25MHZ);
        reset <= 1'b0;
        @(posedge clk_25MHZ);
        check_state(state_led, idle);
        check_flag("tx_request", tx_request, 1'b0);
        check_flag("game_over", game_over, 1'b0);
        check_score(score, 8'd0);
        for (r = 0; r < 4; r++) begin
            rally(r < 2, r[0]);  // Both screens and both serve speeds
        end
        win_notice();
        miss(1'b0);
        repeat (4) @(posedge clk_25MHZ);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* source/ball_if.sv */
`timescale 1ns/1ps

interface ball_if import pong_pkg::*; ();

    // Controller side
    logic                load;
    logic [9:0]          load_x;
    logic [9:0]          load_y;
    logic signed [7:0]   load_vy;
    logic [1:0]          load_gravity;
    logic                run;
    logic                dir_right;
    logic [period_w-1:0] step_period;

    // Physics side
    logic [9:0]          x;
    logic [9:0]          y;
    logic signed [7:0]   vy;
    logic [1:0]          gravity;
    logic                step;

    modport ctrl (
        output load, load_x, load_y, load_vy, load_gravity,
        output run, dir_right, step_period,
        input  x, y, vy, gravity, step
    );

    modport phys (
        input  load, load_x, load_y, load_vy, load_gravity,
        input  run, dir_right, step_period,
        output x, y, vy, gravity, step
    );

endinterface

/* source/ball_physics.sv */
`timescale 1ns/1ps

module ball_physics import pong_pkg::*; (
    input  logic clk_25MHZ,
    input  logic reset,
    input  logic upscale,
    ball_if.phys bus
);

    logic [period_w-1:0] count;
    logic [9:0]          y_max;
    logic [9:0]          x_next;
    logic [9:0]          y_next;
    logic signed [11:0]  y_sum;
    logic signed [7:0]   vy_grav;
    logic signed [7:0]   vy_next;
    logic [1:0]          gravity_next;

    assign y_max = upscale ? screen_h_hi - 10'd1 : screen_h_lo - 10'd1;

    always_comb begin
        if (bus.dir_right) begin
            x_next = bus.x + x_step;
        end else if (bus.x >= x_step) begin
            x_next = bus.x - x_step;
        end else begin
            x_next = '0;  // Never past the left edge
        end

        gravity_next = bus.gravity + 2'd1;
        vy_grav = (bus.gravity == 2'd3) ? bus.vy + 8'sd1 : bus.vy;

        // y moves by the old vy
        y_sum   = $signed({2'b00, bus.y}) + 12'(bus.vy);
        y_next  = y_sum[9:0];
        vy_next = vy_grav;

        if (y_sum >= $signed({2'b00, y_max})) begin
            y_next  = y_max;
            vy_next = -vy_grav;
        end else if (y_sum <= 12'sd0) begin
            y_next  = '0;
            vy_next = -vy_grav;
        end
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            count       <= '0;
            bus.x       <= '0;
            bus.y       <= '0;
            bus.vy      <= '0;
            bus.gravity <= '0;
            bus.step    <= 1'b0;
        end else if (bus.load) begin
            count       <= '0;
            bus.x       <= bus.load_x;
            bus.y       <= bus.load_y;
            bus.vy      <= bus.load_vy;
            bus.gravity <= bus.load_gravity;
            bus.step    <= 1'b0;
        end else if (bus.run) begin
            if (count >= bus.step_period) begin  // Period may shrink on a hit
                count       <= '0;
                bus.x       <= x_next;
                bus.y       <= y_next;
                bus.vy      <= vy_next;
                bus.gravity <= gravity_next;
                bus.step    <= 1'b1;
            end else begin
                count    <= count + 1'b1;
                bus.step <= 1'b0;
            end
        end else begin
            count    <= '0;
            bus.step <= 1'b0;
        end
    end

    // Controller keeps run up through every step it acts on
    step_only_when_running: assert property (
        @(posedge clk_25MHZ) disable iff (reset)
        bus.step |-> bus.run
    );

endmodule

/* source/game_controller.sv */
`timescale 1ns/1ps

module game_controller import pong_pkg::*; (
    input  logic        clk_25MHZ,
    input  logic        reset,
    input  logic        upscale,
    ball_if.ctrl        bus,
    input  logic        hit,
    input  logic [3:0]  speed,
    input  logic        rx_done,
    input  handoff_t    rx_word,
    input  logic        tx_done,
    output logic        tx_request,
    output handoff_t    tx_word,
    output logic        game_over,
    output logic [7:0]  score,
    output game_state_t state_led
);

    game_state_t state;

    logic       win_pending;
    logic [9:0] x_miss;
    logic       listening;
    logic       rx_ball;
    logic       rx_win;
    logic       accept_ball;
    logic       right_miss;
    logic       left_exit;
    handoff_t   ball_msg;
    handoff_t   lose_msg;

    assign x_miss = (upscale ? screen_w_hi : screen_w_lo) - x_right_margin;

    assign listening = (state == idle) || (state == wait_result);
    assign rx_ball   = rx_word.ball.kind == msg_ball;
    assign rx_win    = (rx_word.notice.kind == msg_lose) && rx_word.notice.win;

    assign accept_ball = listening && rx_done && rx_ball;
    assign right_miss  = (state == run_right) && !hit && bus.step && (bus.x >= x_miss);
    assign left_exit   = (state == run_left) && bus.step && (bus.x == 10'd0);

    assign bus.run       = (state == run_right) || (state == run_left);
    assign bus.dir_right = state == run_right;
    assign bus.load_x    = x_serve;
    assign state_led     = state;

    always_comb begin
        ball_msg              = '0;
        ball_msg.ball.kind    = msg_ball;
        ball_msg.ball.y       = bus.y;
        ball_msg.ball.vy      = bus.vy;
        ball_msg.ball.gravity = bus.gravity;
        ball_msg.ball.fast    = bus.step_period <= step_base;
    end

    // Tells the other board it won
    always_comb begin
        lose_msg             = '0;
        lose_msg.notice.kind = msg_lose;
        lose_msg.notice.win  = 1'b1;
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            state           <= idle;
            bus.load        <= 1'b0;
            bus.step_period <= step_base << 1;
            win_pending     <= 1'b0;
            tx_request      <= 1'b0;
            game_over       <= 1'b0;
            score           <= '0;
        end else begin
            bus.load <= 1'b0;
            case (state)
                idle, wait_result: begin
                    if (accept_ball) begin
                        bus.load        <= 1'b1;
                        bus.step_period <= rx_word.ball.fast ? step_base : step_base << 1;
                        win_pending     <= 1'b0;
                        state           <= wait_release;
                        if (game_over) begin  // New game
                            game_over <= 1'b0;
                            score     <= '0;
                        end
                    end else if (rx_done && rx_win) begin
                        win_pending <= 1'b1;
                        state       <= wait_release;
                    end
                end

                wait_release: begin
                    if (!rx_done) begin
                        win_pending <= 1'b0;
                        state       <= win_pending ? idle : run_right;
                    end
                end

                run_right: begin
                    if (hit) begin
                        state           <= run_left;
                        bus.step_period <= step_base / speed;  // speed is never 0
                    end else if (right_miss) begin
                        tx_request <= 1'b1;
                        state      <= send_lose;
                    end
                end

                run_left: begin
                    if (left_exit) begin
                        score      <= score + 8'd1;
                        tx_request <= 1'b1;
                        state      <= send_ball;
                    end
                end

                send_ball: begin
                    if (tx_done) begin
                        tx_request <= 1'b0;
                        state      <= wait_result;
                    end
                end

                send_lose: begin
                    if (tx_done) begin
                        tx_request <= 1'b0;
                        game_over  <= 1'b1;
                        state      <= idle;
                    end
                end

                default: state <= idle;
            endcase
        end
    end

    // Load values and outgoing word
    always_ff @(posedge clk_25MHZ) begin
        if (accept_ball) begin
            bus.load_y       <= rx_word.ball.y;
            bus.load_vy      <= rx_word.ball.vy;
            bus.load_gravity <= rx_word.ball.gravity;
        end
        if (right_miss) begin
            tx_word <= lose_msg;
        end else if (left_exit) begin
            tx_word <= ball_msg;
        end
    end

    tx_word_held: assert property (
        @(posedge clk_25MHZ) disable iff (reset)
        tx_request && !tx_done |=> $stable(tx_word)
    );

endmodule

/* source/paddle_tracker.sv */
`timescale 1ns/1ps

module paddle_tracker import pong_pkg::*; (
    input  logic       clk_25MHZ,
    input  logic       reset,
    input  logic       upscale,
    input  logic       frame,
    input  logic [9:0] paddle_y,
    input  logic [9:0] ball_x,
    input  logic [9:0] ball_y,
    input  logic       dir_right,
    output logic       hit,
    output logic [3:0] speed
);

    logic [9:0]  paddle_last;
    logic [9:0]  delta;
    logic [9:0]  paddle_col;
    logic [10:0] ball_y_ext;
    logic [10:0] paddle_y_ext;
    logic        near;
    logic        contact;
    logic        armed;

    // Paddle motion since the last frame
    assign delta = (paddle_y >= paddle_last) ? paddle_y - paddle_last
                                             : paddle_last - paddle_y;

    assign paddle_col   = paddle_x(upscale);
    assign ball_y_ext   = {1'b0, ball_y};
    assign paddle_y_ext = {1'b0, paddle_y};

    // Ball within paddle_half of the paddle center
    assign near = (ball_y_ext + paddle_half >= paddle_y_ext) &&
                  (ball_y_ext <= paddle_y_ext + paddle_half);

    assign contact = dir_right && (ball_x >= paddle_col) && near;

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            paddle_last <= '0;
            speed       <= speed_min;
        end else if (frame) begin
            paddle_last <= paddle_y;
            if (delta < speed_min) begin
                speed <= speed_min;
            end else if (delta > speed_max) begin
                speed <= speed_max;
            end else begin
                speed <= delta[3:0];
            end
        end
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            hit   <= 1'b0;
            armed <= 1'b1;
        end else begin
            hit <= contact && armed;
            if (contact && armed) begin
                armed <= 1'b0;  // One hit per pass
            end else if (!dir_right) begin
                armed <= 1'b1;
            end
        end
    end

    single_cycle_hit: assert property (
        @(posedge clk_25MHZ) disable iff (reset)
        hit |=> !hit
    );

endmodule

/* source/pong_board_top.sv */
`timescale 1ns/1ps

module pong_board_top import pong_pkg::*; (
    input  logic                 clk_25MHZ,
    input  logic                 reset,
    input  logic                 upscale,    // 640x480 when high
    input  logic                 frame,
    input  logic [9:0]           paddle_y,
    input  logic                 rx_done,
    input  logic [handoff_w-1:0] rx_word,
    input  logic                 tx_done,
    output logic                 tx_request,
    output logic [handoff_w-1:0] tx_word,
    output logic [9:0]           ball_x,
    output logic [9:0]           ball_y,
    output logic                 game_over,
    output logic [7:0]           score,
    output game_state_t          state_led
);

    logic       hit;
    logic [3:0] speed;

    ball_if bus ();

    assign ball_x = bus.x;
    assign ball_y = bus.y;

    ball_physics i_ball_physics (
        .clk_25MHZ (clk_25MHZ),
        .reset     (reset),
        .upscale   (upscale),
        .bus       (bus.phys)
    );

    // Reads the ball directly beside the physics
    paddle_tracker i_paddle_tracker (
        .clk_25MHZ (clk_25MHZ),
        .reset     (reset),
        .upscale   (upscale),
        .frame     (frame),
        .paddle_y  (paddle_y),
        .ball_x    (bus.x),
        .ball_y    (bus.y),
        .dir_right (bus.dir_right),
        .hit       (hit),
        .speed     (speed)
    );

    game_controller i_game_controller (
        .clk_25MHZ  (clk_25MHZ),
        .reset      (reset),
        .upscale    (upscale),
        .bus        (bus.ctrl),
        .hit        (hit),
        .speed      (speed),
        .rx_done    (rx_done),
        .rx_word    (rx_word),
        .tx_done    (tx_done),
        .tx_request (tx_request),
        .tx_word    (tx_word),
        .game_over  (game_over),
        .score      (score),
        .state_led  (state_led)
    );

endmodule

/* source/pong_pkg.sv */
package pong_pkg;

    // Screen sizes selected by upscale
    localparam logic [9:0] screen_w_hi = 10'd640;
    localparam logic [9:0] screen_w_lo = 10'd320;
    localparam logic [9:0] screen_h_hi = 10'd480;
    localparam logic [9:0] screen_h_lo = 10'd240;

    localparam int period_w  = 20;
    localparam int handoff_w = 40;

    // Cycles per step at speed 1
    localparam logic [period_w-1:0] step_base = 20'd2700;

    localparam logic [9:0] x_serve        = 10'd20;
    localparam logic [9:0] x_step         = 10'd10;
    localparam logic [9:0] x_right_margin = 10'd20;

    localparam logic [9:0] paddle_x_hi = 10'd600;
    localparam logic [9:0] paddle_x_lo = 10'd280;
    localparam logic [9:0] paddle_half = 10'd24;

    localparam logic [3:0] speed_min = 4'd1;
    localparam logic [3:0] speed_max = 4'd15;

    localparam logic [1:0] msg_ball = 2'b01;
    localparam logic [1:0] msg_lose = 2'b10;

    function automatic logic [9:0] paddle_x(input logic upscale);
        return upscale ? paddle_x_hi : paddle_x_lo;
    endfunction

    // Link word read as a ball handoff or as a notice
    typedef union packed {
        struct packed {
            logic [1:0]        kind;
            logic [9:0]        y;
            logic signed [7:0] vy;
            logic [1:0]        gravity;
            logic              fast;     // Period is step_base when set
            logic [16:0]       spare;
        } ball;
        struct packed {
            logic [1:0]  kind;
            logic        win;
            logic [36:0] pad;
        } notice;
    } handoff_t;

    typedef enum logic [2:0] {
        idle,
        wait_release,
        run_right,
        run_left,
        send_lose,
        send_ball,
        wait_result
    } game_state_t;

endpackage

/* verilog.f */
+incdir+dv
source/pong_pkg.sv
source/ball_if.sv
source/ball_physics.sv
source/paddle_tracker.sv
source/game_controller.sv
source/pong_board_top.sv
dv/tb_pong_board.sv
